//--- dv/commitChecker.sv
`default_nettype none

module commitChecker (
    input  wire logic                    clk,
    input  wire logic                    active,
    input  wire logic [7:0]              rowIdx,
    input  wire commitPkg::renameRelease expRel0,
    input  wire commitPkg::renameRelease expRel1,
    input  wire logic                    expStore,
    input  wire commitPkg::nlpUpdate     expNlp,
    input  wire commitPkg::fetchRedirect expRedir,
    input  wire logic                    expExl,
    input  wire logic [31:0]             expEpc,
    input  wire logic [5:0]              expExt,
    input  wire logic [4:0]              expCode,
    input  wire logic [31:0]             expBad,
    input  wire logic                    robReady,
    input  wire commitPkg::renameRelease release0,
    input  wire commitPkg::renameRelease release1,
    input  wire logic                    storeFire,
    input  wire commitPkg::nlpUpdate     nlp,
    input  wire commitPkg::fetchRedirect redirect,
    input  wire logic                    flushReq,
    input  wire commitPkg::cp0View       cp0Out,
    output int                           errors,
    output int                           rowsDone
);
    timeunit 1ns;
    timeprecision 100ps;

    int                      errCount = 0;
    int                      doneCount = 0;
    int                      rowErrors = 0;
    int                      prevErrs = 0;
    logic                    prevActive = 1'b0;
    logic [7:0]              prevIdx;
    commitPkg::renameRelease pRel0;
    commitPkg::renameRelease pRel1;
    commitPkg::nlpUpdate     pNlp;
    commitPkg::fetchRedirect pRedir;
    logic                    pExl;
    logic [31:0]             pEpc;
    logic [5:0]              pExt;
    logic [4:0]              pCode;
    logic [31:0]             pBad;

    assign errors   = errCount;
    assign rowsDone = doneCount;

    task automatic compareField(string name, logic [31:0] expV, logic [31:0] actV);
        if (expV !== actV) begin
            $display("error at %0d ns: %s expected %h got %h", $time, name, expV, actV);
            errCount++;
            rowErrors++;
        end
    endtask

    // registered outputs of a row show up one cycle after it
    always @(negedge clk) begin
        if (prevActive) begin
            rowErrors = prevErrs;
            compareField("release0.valid", 32'(pRel0.valid), 32'(release0.valid));
            if (pRel0.valid) begin
                compareField("release0", 32'(pRel0), 32'(release0));
            end
            compareField("release1.valid", 32'(pRel1.valid), 32'(release1.valid));
            if (pRel1.valid) begin
                compareField("release1", 32'(pRel1), 32'(release1));
            end
            compareField("nlp.valid", 32'(pNlp.valid), 32'(nlp.valid));
            if (pNlp.valid) begin
                compareField("nlp.pc", pNlp.pc, nlp.pc);
                compareField("nlp.target", pNlp.target, nlp.target);
                compareField("nlp.shouldTake", 32'(pNlp.shouldTake), 32'(nlp.shouldTake));
                compareField("nlp.bimState", 32'(pNlp.bimState), 32'(nlp.bimState));
            end
            compareField("redirect.valid", 32'(pRedir.valid), 32'(redirect.valid));
            if (pRedir.valid) begin
                compareField("redirect.pc", pRedir.pc, redirect.pc);
            end
            compareField("flushReq", 32'(pRedir.valid), 32'(flushReq));
            compareField("robReady", 32'(!pRedir.valid), 32'(robReady));
            compareField("cp0Out.statusExl", 32'(pExl), 32'(cp0Out.statusExl));
            compareField("cp0Out.epc", pEpc, cp0Out.epc);
            compareField("cp0Out.causeIp", 32'(pExt), 32'(cp0Out.causeIp));
            compareField("cp0Out.excCode", 32'(pCode), 32'(cp0Out.excCode));
            compareField("cp0Out.badVAddr", pBad, cp0Out.badVAddr);
            if (rowErrors == 0) begin
                $display("row %0d pass", prevIdx);
            end else begin
                $display("row %0d fail, %0d mismatches", prevIdx, rowErrors);
            end
            doneCount++;
        end
        if (active) begin
            rowErrors = 0;
            compareField("storeFire", 32'(expStore), 32'(storeFire));   // same cycle
            prevErrs = rowErrors;
        end
        prevActive = active;
        prevIdx    = rowIdx;
        pRel0      = expRel0;
        pRel1      = expRel1;
        pNlp       = expNlp;
        pRedir     = expRedir;
        pExl       = expExl;
        pEpc       = expEpc;
        pExt       = expExt;
        pCode      = expCode;
        pBad       = expBad;
    end

endmodule

`default_nettype wire

//--- dv/commitTb.sv
`default_nettype none

`include "commit_cfg.svh"

module commitTb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        uopPkg::robPair          pair;
        logic [5:0]              extInt;
        commitPkg::cp0Write      wr;
        commitPkg::renameRelease rel0;
        commitPkg::renameRelease rel1;
        logic                    store;
        commitPkg::nlpUpdate     nlp;
        commitPkg::fetchRedirect redir;
        logic                    exl;
        logic [31:0]             epc;
        logic [4:0]              code;
        logic [31:0]             badVAddr;
    } stimRow;

    logic                    clk;
    logic                    rst;
    logic [5:0]              extInt;
    uopPkg::robPair          rob;
    commitPkg::cp0Write      cp0Wr;
    logic                    robReady;
    commitPkg::renameRelease release0;
    commitPkg::renameRelease release1;
    logic                    storeFire;
    commitPkg::nlpUpdate     nlp;
    commitPkg::fetchRedirect redirect;
    logic                    flushReq;
    commitPkg::cp0View       cp0Out;

    stimRow             rows[$];
    stimRow             cur;
    logic               rowActive;
    logic [7:0]         rowIdx;
    int                 seed;
    logic [31:0]        rnd;
    logic               modelExl;   // expected CP0 state seen after each row
    logic [31:0]        modelEpc;
    logic [4:0]         modelCode;
    logic [31:0]        modelBad;
    logic [5:0]         modelExt;
    commitPkg::cp0Write nextWr;
    int                 errors;
    int                 rowsDone;

    commitTop uut (
        .clk(clk), .rst(rst), .extInt(extInt), .rob(rob), .robReady(robReady),
        .cp0Wr(cp0Wr), .release0(release0), .release1(release1), .storeFire(storeFire),
        .nlp(nlp), .redirect(redirect), .flushReq(flushReq), .cp0Out(cp0Out)
    );

    commitChecker chk (
        .clk(clk), .active(rowActive), .rowIdx(rowIdx),
        .expRel0(cur.rel0), .expRel1(cur.rel1), .expStore(cur.store), .expNlp(cur.nlp),
        .expRedir(cur.redir), .expExl(cur.exl), .expEpc(cur.epc),
        .expExt(cur.extInt), .expCode(cur.code), .expBad(cur.badVAddr),
        .robReady(robReady), .release0(release0), .release1(release1),
        .storeFire(storeFire), .nlp(nlp), .redirect(redirect), .flushReq(flushReq),
        .cp0Out(cp0Out), .errors(errors), .rowsDone(rowsDone)
    );

    always #2 clk = !clk;

    function automatic uopPkg::robUop aluUop(logic dstWe);
        uopPkg::robUop u;
        u = '0;
        u.valid = 1'b1;
        u.op    = uopPkg::opAlu;
        rnd     = $random(seed);
        u.pc    = {rnd[31:2], 2'b00};
        rnd     = $random(seed);
        u.dstWe    = dstWe;
        u.dstArch  = rnd[4:0];
        u.dstPhys  = rnd[13:8];
        u.dstStale = rnd[21:16];
        return u;
    endfunction

    function automatic uopPkg::robUop branchUop(uopPkg::branchKind kind, logic taken,
                                                logic predTaken, logic targetMiss);
        uopPkg::robUop u;
        u = aluUop(1'b0);
        rnd = $random(seed);
        u.op        = uopPkg::opBranch;
        u.brKind    = kind;
        u.taken     = taken;
        u.predTaken = predTaken;
        u.brAddr    = {rnd[31:2], 2'b00};
        u.predAddr  = targetMiss ? u.brAddr + 32'h40 : u.brAddr;
        u.bimState  = rnd[1:0];
        return u;
    endfunction

    function automatic commitPkg::renameRelease expRelease(uopPkg::robUop u, logic kill);
        commitPkg::renameRelease e;
        e.valid    = u.valid && !u.busy && !u.committed;
        e.wrCommit = u.dstWe && !kill;   // killed slot frees its new phys
        e.arch     = u.dstArch;
        e.phys     = u.dstPhys;
        e.stale    = u.dstStale;
        return e;
    endfunction

    task automatic addRow(uopPkg::robUop s0, uopPkg::robUop s1, logic kill0, logic kill1,
                          logic store, logic redirValid, logic [31:0] redirPc);
        stimRow r;
        r = '0;
        r.pair   = '{valid: s0.valid || s1.valid, slot0: s0, slot1: s1};
        r.extInt = modelExt;
        r.wr     = nextWr;
        r.rel0   = expRelease(s0, kill0);
        r.rel1   = expRelease(s1, kill1);
        r.store  = store;
        if (r.rel0.valid && s0.brKind != uopPkg::brNone) begin
            r.nlp = '{valid: 1'b1, pc: s0.pc, target: s0.brAddr,
                      shouldTake: s0.taken, bimState: s0.bimState};
        end
        r.redir    = '{valid: redirValid, pc: redirPc};
        r.exl      = modelExl;
        r.epc      = modelEpc;
        r.code     = modelCode;
        r.badVAddr = modelBad;
        rows.push_back(r);
        nextWr = '0;
    endtask

    task automatic addIdle();
        addRow('0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic buildTable();
        uopPkg::robUop s0;
        uopPkg::robUop s1;
        addRow(aluUop(1'b1), aluUop(1'b0), 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
        s0 = aluUop(1'b1);
        s0.busy = 1'b1;
        s1 = aluUop(1'b1);
        s1.committed = 1'b1;
        addRow(s0, s1, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
        s1 = aluUop(1'b0);
        s1.op = uopPkg::opSw;
        addRow(aluUop(1'b1), s1, 1'b0, 1'b0, 1'b1, 1'b0, 32'd0);
        s0 = aluUop(1'b0);
        s0.op = uopPkg::opSw;
        addRow(s0, aluUop(1'b1), 1'b0, 1'b0, 1'b1, 1'b0, 32'd0);
        // branches, delay slot in slot 1
        s1 = aluUop(1'b1);
        s1.isDS = 1'b1;
        addRow(branchUop(uopPkg::brCond, 1'b1, 1'b1, 1'b0), s1,
               1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
        s0 = branchUop(uopPkg::brCond, 1'b1, 1'b0, 1'b0);
        addRow(s0, s1, 1'b0, 1'b0, 1'b0, 1'b1, s0.brAddr);
        addIdle();
        s0 = branchUop(uopPkg::brCond, 1'b0, 1'b1, 1'b0);
        addRow(s0, s1, 1'b0, 1'b0, 1'b0, 1'b1, s0.pc + 32'd8);
        addIdle();
        // target miss, delay slot still to come
        s0 = branchUop(uopPkg::brJump, 1'b1, 1'b1, 1'b1);
        s1 = '0;
        s1.valid = 1'b1;
        s1.op    = uopPkg::opBubble;
        addRow(s0, s1, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
        addIdle();
        s1 = aluUop(1'b1);
        s1.isDS = 1'b1;
        addRow(s1, aluUop(1'b1), 1'b0, 1'b0, 1'b0, 1'b1, s0.brAddr);
        addIdle();
        // syscall in slot 0 kills both slots
        s0 = aluUop(1'b1);
        s0.op       = uopPkg::opSyscall;
        s0.causeExc = 1'b1;
        s0.excCode  = `EXC_SYS;
        addRow(s0, aluUop(1'b1), 1'b1, 1'b1, 1'b0, 1'b1, `EXC_VECTOR);
        modelExl  = 1'b1;
        modelEpc  = s0.pc;
        modelCode = `EXC_SYS;
        addIdle();
        s0 = aluUop(1'b0);
        s0.op = uopPkg::opEret;
        addRow(s0, aluUop(1'b1), 1'b1, 1'b1, 1'b0, 1'b1, modelEpc);
        modelExl = 1'b0;
        addIdle();
        s1 = aluUop(1'b1);
        s1.op       = uopPkg::opSyscall;
        s1.causeExc = 1'b1;
        s1.excCode  = `EXC_SYS;
        s1.isDS     = 1'b1;
        addRow(aluUop(1'b1), s1, 1'b0, 1'b1, 1'b0, 1'b1, `EXC_VECTOR);
        modelExl  = 1'b1;
        modelEpc  = s1.pc - 32'd4;
        modelCode = `EXC_SYS;
        addIdle();
        addRow(s0, aluUop(1'b1), 1'b1, 1'b1, 1'b0, 1'b1, modelEpc);
        modelExl = 1'b0;
        addIdle();
        // misaligned load in slot 0
        s1 = aluUop(1'b1);
        s1.op          = uopPkg::opLoad;
        s1.causeExc    = 1'b1;
        s1.excCode     = `EXC_ADEL;
        s1.badVAddr    = $random(seed);
        s1.badVAddr[0] = 1'b1;
        addRow(s1, aluUop(1'b1), 1'b1, 1'b1, 1'b0, 1'b1, `EXC_VECTOR);
        modelExl  = 1'b1;
        modelEpc  = s1.pc;
        modelCode = `EXC_ADEL;
        modelBad  = s1.badVAddr;
        addIdle();
        addRow(s0, aluUop(1'b1), 1'b1, 1'b1, 1'b0, 1'b1, modelEpc);
        modelExl = 1'b0;
        addIdle();
        // line 0 high, IE on but IM clear
        nextWr = '{en: 1'b1, sel: commitPkg::selStatus, data: 32'h0000_0001};
        modelExt = 6'b000001;
        addRow(aluUop(1'b1), aluUop(1'b1), 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
        addRow(aluUop(1'b1), aluUop(1'b1), 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
        nextWr = '{en: 1'b1, sel: commitPkg::selStatus, data: 32'h0000_0401};
        addIdle();
        s1 = aluUop(1'b1);
        addRow(s1, aluUop(1'b1), 1'b1, 1'b1, 1'b0, 1'b1, `EXC_VECTOR);
        modelExl  = 1'b1;
        modelEpc  = s1.pc;
        modelCode = `EXC_INT;
        addIdle();
        addRow(aluUop(1'b1), aluUop(1'b1), 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);   // EXL masks it
        modelExt = 6'b000000;
        addRow(s0, aluUop(1'b1), 1'b1, 1'b1, 1'b0, 1'b1, modelEpc);
        modelExl = 1'b0;
        addIdle();
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        extInt    = '0;
        rob       = '0;
        cp0Wr     = '0;
        cur       = '0;
        rowActive = 1'b0;
        rowIdx    = '0;
        seed      = 19;
        modelExl  = 1'b0;
        modelEpc  = '0;
        modelCode = '0;
        modelBad  = '0;
        modelExt  = '0;
        nextWr    = '0;
        buildTable();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            cur       = rows[i];
            rob       = cur.pair;
            extInt    = cur.extInt;
            cp0Wr     = cur.wr;
            rowIdx    = 8'(i);
            rowActive = 1'b1;
        end
        @(posedge clk);
        #1;
        rowActive = 1'b0;
        rob       = '0;
        cp0Wr     = '0;
        @(posedge clk);
        #1;
        $display("%0d of %0d rows checked, %0d errors", rowsDone, rows.size(), errors);
        if (errors == 0 && rowsDone == rows.size()) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        #((rows.size() + 20) * 4);
        $display("watchdog expired at %0d ns, the run hung near row %0d", $time, rowIdx);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/branchCheck.sv
`default_nettype none

module branchCheck (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire uopPkg::robUop           slot0,
    input  wire uopPkg::robUop           slot1,
    input  wire logic                    good0,
    input  wire logic                    good1,
    input  wire logic                    flush,
    output commitPkg::fetchRedirect      redirect
);
    logic        dirMiss;
    logic        targetMiss;
    logic        mispredict;
    logic [31:0] realTarget;
    logic        pending;
    logic        waitDS;
    logic [31:0] target;

    // only slot 0 can hold a branch, its delay slot follows
    assign dirMiss    = slot0.taken != slot0.predTaken;
    assign targetMiss = slot0.taken && (slot0.brAddr != slot0.predAddr);
    assign mispredict = good0 && (slot0.brKind != uopPkg::brNone) && (dirMiss || targetMiss);
    assign realTarget = slot0.taken ? slot0.brAddr : slot0.pc + 32'd8;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pending <= 1'b0;
            waitDS  <= 1'b0;
        end else if (redirect.valid) begin
            pending <= 1'b0;
        end else if (mispredict) begin
            pending <= 1'b1;
            waitDS  <= !good1 || (slot1.op == uopPkg::opBubble);
        end else if (waitDS && good0) begin
            waitDS  <= 1'b0;    // delay slot retired
        end
    end

    always_ff @(posedge clk) begin
        if (mispredict) begin
            target <= realTarget;
        end
    end

    assign redirect.valid = pending && !waitDS;
    assign redirect.pc    = target;

endmodule

`default_nettype wire

//--- logic/commitCtrl.sv
`default_nettype none

`include "commit_cfg.svh"

module commitCtrl (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire uopPkg::robPair          rob,
    output logic                         robReady,
    input  wire logic                    intPending,
    input  wire commitPkg::cp0View       cp0,
    input  wire commitPkg::fetchRedirect mispredict,
    output commitPkg::renameRelease      release0,
    output commitPkg::renameRelease      release1,
    output logic                         storeFire,
    output commitPkg::nlpUpdate          nlp,
    output commitPkg::excReport          exc,
    output commitPkg::fetchRedirect      redirect,
    output logic                         flushReq
);
    logic                good0;
    logic                good1;
    logic                fault0;
    logic                fault1;
    logic                intTake;
    logic                kill0;
    logic                kill1;
    commitPkg::excReport excNext;

    function automatic logic isStore(uopPkg::uopOp op);
        return op == uopPkg::opSb || op == uopPkg::opSh || op == uopPkg::opSw;
    endfunction

    function automatic commitPkg::excKind kindOf(uopPkg::robUop u);
        commitPkg::excKind k;
        if (u.op == uopPkg::opEret) begin
            k = commitPkg::excEret;
        end else if (u.excCode == `EXC_SYS) begin
            k = commitPkg::excSyscall;
        end else begin
            k = commitPkg::excAddrError;
        end
        return k;
    endfunction

    assign robReady = !flushReq;   // hold the pair during a flush
    assign good0 = rob.valid && robReady && rob.slot0.valid
                   && !rob.slot0.committed && !rob.slot0.busy;
    assign good1 = rob.valid && robReady && rob.slot1.valid
                   && !rob.slot1.committed && !rob.slot1.busy;

    assign intTake = intPending && good0;
    assign fault0  = good0 && (rob.slot0.causeExc || rob.slot0.op == uopPkg::opEret);
    assign fault1  = good1 && (rob.slot1.causeExc || rob.slot1.op == uopPkg::opEret);
    assign kill0   = intTake || fault0;
    assign kill1   = kill0 || fault1;   // slot 1 dies with slot 0

    assign storeFire = (good0 && isStore(rob.slot0.op) && !kill0)
                       || (good1 && isStore(rob.slot1.op) && !kill1);

    // interrupt first, then program order
    always_comb begin
        excNext = '0;
        if (intTake) begin
            excNext.take = 1'b1;
            excNext.kind = commitPkg::excInterrupt;
            excNext.pc   = rob.slot0.pc;
            excNext.isDS = rob.slot0.isDS;
        end else if (fault0) begin
            excNext = '{take: 1'b1, kind: kindOf(rob.slot0), pc: rob.slot0.pc,
                        isDS: rob.slot0.isDS, badVAddr: rob.slot0.badVAddr};
        end else if (fault1) begin
            excNext = '{take: 1'b1, kind: kindOf(rob.slot1), pc: rob.slot1.pc,
                        isDS: rob.slot1.isDS, badVAddr: rob.slot1.badVAddr};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            release0 <= '0;
            release1 <= '0;
            nlp      <= '0;
            exc      <= '0;
        end else begin
            release0 <= '{valid: good0, wrCommit: rob.slot0.dstWe && !kill0,
                          arch: rob.slot0.dstArch, phys: rob.slot0.dstPhys,
                          stale: rob.slot0.dstStale};
            release1 <= '{valid: good1, wrCommit: rob.slot1.dstWe && !kill1,
                          arch: rob.slot1.dstArch, phys: rob.slot1.dstPhys,
                          stale: rob.slot1.dstStale};
            nlp      <= '{valid: good0 && rob.slot0.brKind != uopPkg::brNone,
                          pc: rob.slot0.pc, target: rob.slot0.brAddr,
                          shouldTake: rob.slot0.taken, bimState: rob.slot0.bimState};
            exc      <= excNext;
        end
    end

    // epc still holds the old value during the ERET flush
    always_comb begin
        redirect = mispredict;
        if (exc.take) begin
            redirect.valid = 1'b1;
            redirect.pc    = (exc.kind == commitPkg::excEret) ? cp0.epc : `EXC_VECTOR;
        end
    end

    assign flushReq = redirect.valid;

endmodule

`default_nettype wire

//--- logic/commitPkg.sv
`default_nettype none

package commitPkg;

    typedef enum logic [2:0] {
        excNone,
        excInterrupt,
        excSyscall,
        excAddrError,
        excEret
    } excKind;

    typedef enum logic [1:0] {
        selStatus,
        selCause,
        selEpc
    } cp0Sel;

    typedef struct packed {
        logic       valid;
        logic       wrCommit;    // low frees phys instead of stale
        logic [4:0] arch;
        logic [5:0] phys;
        logic [5:0] stale;
    } renameRelease;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetchRedirect;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
        logic        shouldTake;
        logic [1:0]  bimState;
    } nlpUpdate;

    typedef struct packed {
        logic        take;
        excKind      kind;
        logic [31:0] pc;
        logic        isDS;
        logic [31:0] badVAddr;
    } excReport;

    typedef struct packed {
        logic        en;
        cp0Sel       sel;
        logic [31:0] data;
    } cp0Write;

    typedef struct packed {
        logic        statusIe;
        logic        statusExl;
        logic [7:0]  statusIm;
        logic [1:0]  causeIpSw;
        logic [5:0]  causeIp;
        logic [4:0]  excCode;
        logic [31:0] epc;
        logic [31:0] badVAddr;
    } cp0View;

endpackage

`default_nettype wire

//--- logic/commitTop.sv
`default_nettype none

module commitTop (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [5:0]             extInt,
    input  wire uopPkg::robPair         rob,
    output logic                        robReady,
    input  wire commitPkg::cp0Write     cp0Wr,
    output commitPkg::renameRelease     release0,
    output commitPkg::renameRelease     release1,
    output logic                        storeFire,
    output commitPkg::nlpUpdate         nlp,
    output commitPkg::fetchRedirect     redirect,
    output logic                        flushReq,
    output commitPkg::cp0View           cp0Out
);
    logic [5:0]              lines;
    logic                    intPending;
    commitPkg::fetchRedirect mispredict;
    commitPkg::excReport     excRep;

    interruptSync intSync (
        .clk(clk), .rst(rst), .extInt(extInt), .cp0(cp0Out),
        .lines(lines), .intPending(intPending)
    );

    // good bits qualified the same way as in ctrl, robReady gating included
    branchCheck brCheck (
        .clk(clk), .rst(rst), .slot0(rob.slot0), .slot1(rob.slot1),
        .good0(rob.valid && robReady && rob.slot0.valid
               && !rob.slot0.committed && !rob.slot0.busy),
        .good1(rob.valid && robReady && rob.slot1.valid
               && !rob.slot1.committed && !rob.slot1.busy),
        .flush(excRep.take), .redirect(mispredict)
    );

    cp0Regs cp0 (
        .clk(clk), .rst(rst), .exc(excRep), .lines(lines), .wr(cp0Wr), .view(cp0Out)
    );

    commitCtrl ctrl (
        .clk(clk), .rst(rst), .rob(rob), .robReady(robReady),
        .intPending(intPending), .cp0(cp0Out), .mispredict(mispredict),
        .release0(release0), .release1(release1), .storeFire(storeFire),
        .nlp(nlp), .exc(excRep), .redirect(redirect), .flushReq(flushReq)
    );

endmodule

`default_nettype wire

//--- logic/commit_cfg.svh
`ifndef COMMIT_CFG_SVH
`define COMMIT_CFG_SVH

// fetch target on any exception or interrupt
`define EXC_VECTOR 32'hBFC0_0380

// BEV set, interrupts off, all lines masked
`define STATUS_RESET 32'h0040_0000

// Cause.ExcCode values
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_SYS  5'd8

`endif

//--- logic/cp0Regs.sv
`default_nettype none

`include "commit_cfg.svh"

module cp0Regs (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire commitPkg::excReport exc,
    input  wire logic [5:0]          lines,
    input  wire commitPkg::cp0Write  wr,
    output commitPkg::cp0View        view
);
    localparam logic [31:0] statusReset = `STATUS_RESET;

    logic        statusIe;
    logic        statusExl;
    logic [7:0]  statusIm;
    logic [1:0]  causeIpSw;
    logic [4:0]  excCode;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic [4:0]  codeNext;

    always_comb begin
        case (exc.kind)
            commitPkg::excInterrupt: codeNext = `EXC_INT;
            commitPkg::excSyscall:   codeNext = `EXC_SYS;
            default:                 codeNext = `EXC_ADEL;
        endcase
    end

    // exception update wins over a software write
    always_ff @(posedge clk) begin
        if (rst) begin
            statusIe  <= statusReset[0];
            statusExl <= statusReset[1];
            statusIm  <= statusReset[15:8];
            causeIpSw <= '0;
            excCode   <= '0;
            epc       <= '0;
            badVAddr  <= '0;
        end else if (exc.take) begin
            if (exc.kind == commitPkg::excEret) begin
                statusExl <= 1'b0;
            end else begin
                statusExl <= 1'b1;
                excCode   <= codeNext;
                epc       <= exc.isDS ? exc.pc - 32'd4 : exc.pc;   // restart at the branch
                if (exc.kind == commitPkg::excAddrError) begin
                    badVAddr <= exc.badVAddr;
                end
            end
        end else if (wr.en) begin
            case (wr.sel)
                commitPkg::selStatus: begin
                    statusIe  <= wr.data[0];
                    statusExl <= wr.data[1];
                    statusIm  <= wr.data[15:8];
                end
                commitPkg::selCause: causeIpSw <= wr.data[9:8];
                commitPkg::selEpc:   epc <= wr.data;
                default: ;
            endcase
        end
    end

    assign view = '{statusIe: statusIe, statusExl: statusExl, statusIm: statusIm,
                    causeIpSw: causeIpSw, causeIp: lines, excCode: excCode,
                    epc: epc, badVAddr: badVAddr};

endmodule

`default_nettype wire

//--- logic/interruptSync.sv
`default_nettype none

module interruptSync (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [5:0]        extInt,
    input  wire commitPkg::cp0View cp0,
    output logic [5:0]             lines,
    output logic                   intPending
);
    logic [7:0] ipAll;

    // lines are async to the core
    always_ff @(posedge clk) begin
        if (rst) begin
            lines <= '0;
        end else begin
            lines <= extInt;
        end
    end

    assign ipAll = {lines, cp0.causeIpSw};   // hw lines on IP7..IP2

    assign intPending = (|(ipAll & cp0.statusIm)) && cp0.statusIe && !cp0.statusExl;

endmodule

`default_nettype wire

//--- logic/uopPkg.sv
`default_nettype none

package uopPkg;

    typedef enum logic [3:0] {
        opAlu,
        opLoad,
        opSb,
        opSh,
        opSw,
        opBranch,
        opEret,
        opSyscall,
        opBubble        // empty delay slot
    } uopOp;

    typedef enum logic [1:0] {
        brNone,
        brCond,
        brJump,
        brJumpReg
    } branchKind;

    typedef struct packed {
        logic        valid;
        logic        busy;
        logic        committed;
        uopOp        op;
        logic [31:0] pc;
        logic        isDS;
        logic        dstWe;
        logic [4:0]  dstArch;
        logic [5:0]  dstPhys;
        logic [5:0]  dstStale;   // previous mapping, freed on commit
        branchKind   brKind;
        logic        taken;
        logic        predTaken;
        logic [31:0] brAddr;
        logic [31:0] predAddr;
        logic [1:0]  bimState;
        logic        causeExc;
        logic [4:0]  excCode;
        logic [31:0] badVAddr;
    } robUop;

    typedef struct packed {
        logic  valid;
        robUop slot0;
        robUop slot1;
    } robPair;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the commit stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary -j 0 --top-module commitTb -f sim.f -o commitSim > build.log 2>&1 \
    && ./obj_dir/commitSim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat build.log; exit 1; }

grep -q "^Test OK$" sim.log \
    && echo "simulation passed" \
    || { cat sim.log; echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+logic
logic/uopPkg.sv
logic/commitPkg.sv
logic/interruptSync.sv
logic/branchCheck.sv
logic/cp0Regs.sv
logic/commitCtrl.sv
logic/commitTop.sv
dv/commitChecker.sv
dv/commitTb.sv
